// File: Makefile
TOP = dtlb_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f *.sv
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'sim passed'

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: dtlb.sv
// ========================================
// Data TLB top: controller, eight ways
// and result merge
// ========================================
`timescale 1ns/1ps
`default_nettype none

module dtlb (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           read_en,
  input  wire                           lru_en,
  input  wire [dtlb_pkg::tag_bits:0]    addr,
  input  wire [dtlb_pkg::asid_bits-1:0] asid,
  output logic                          read_hit,
  output logic [dtlb_pkg::way_bits-1:0] read_way,
  output logic [dtlb_pkg::pte_bits-1:0] read_data,
  output logic [dtlb_pkg::pte_bits-1:0] read_data_next,
  input  wire                           write_en,
  input  wire                           write_update,
  input  wire                           write_invl,
  input  wire [dtlb_pkg::tag_bits-1:0]  write_addr,
  input  wire [dtlb_pkg::asid_bits-1:0] write_asid,
  input  wire [dtlb_pkg::pte_bits-1:0]  write_data0,
  input  wire [dtlb_pkg::pte_bits-1:0]  write_data1,
  input  wire [dtlb_pkg::pte_bits-1:0]  write_data2,
  input  wire                           force_way_en,
  input  wire [dtlb_pkg::way_bits-1:0]  force_way,
  output logic                          init_busy
);

  dtlb_bus_if bus ();

  wire dtlb_pkg::way_result_t [dtlb_pkg::way_count-1:0] way_results;
  wire [dtlb_pkg::age_bits-1:0]                        ref_age;

  dtlb_ctrl ctrl_inst (
    .clk(clk), .rst(rst), .read_en(read_en), .lru_en(lru_en), .addr(addr), .asid(asid),
    .write_en(write_en), .write_update(write_update), .write_invl(write_invl),
    .write_addr(write_addr), .write_asid(write_asid), .write_data0(write_data0),
    .write_data1(write_data1), .write_data2(write_data2), .force_way_en(force_way_en),
    .force_way(force_way), .bus(bus.ctrl), .init_busy(init_busy)
  );

  for (genvar k = 0; k < dtlb_pkg::way_count; k++) begin : g_way
    dtlb_way #(.way_no(k)) way_inst (
      .clk(clk),
      .rst(rst),
      .bus(bus.way),
      .ref_age(ref_age),
      .result(way_results[k])
    );
  end

  dtlb_merge merge_inst (
    .results(way_results),
    .init(bus.init),
    .read_sel(addr[0]),
    .write_active(bus.wr_en),
    .read_hit(read_hit),
    .read_way(read_way),
    .read_data(read_data),
    .read_data_next(read_data_next),
    .ref_age(ref_age)
  );

endmodule

`default_nettype wire

// File: dtlb_bus_if.sv
// ========================================
// Broadcast bus from the TLB controller
// to every way
// ========================================
`timescale 1ns/1ps
`default_nettype none

interface dtlb_bus_if;

  logic [dtlb_pkg::tag_bits-1:0]  look_tag;
  logic [dtlb_pkg::asid_bits-1:0] look_asid;
  logic                           look_lru_en;

  logic                           wr_en;      // Already masked during the sweep
  logic                           wr_update;
  logic                           wr_invl;
  logic [dtlb_pkg::tag_bits-1:0]  wr_tag;
  logic [dtlb_pkg::asid_bits-1:0] wr_asid;
  logic [dtlb_pkg::pte_bits-1:0]  wr_data0;
  logic [dtlb_pkg::pte_bits-1:0]  wr_data1;
  logic [dtlb_pkg::pte_bits-1:0]  wr_data2;

  logic                           force_en;
  logic [dtlb_pkg::way_bits-1:0]  force_way;

  logic                           init;
  logic [dtlb_pkg::set_bits-1:0]  init_set;

  logic [dtlb_pkg::set_bits-1:0]  age_set;
  logic                           age_upd;

  modport ctrl (
    output look_tag, look_asid, look_lru_en,
    output wr_en, wr_update, wr_invl, wr_tag, wr_asid, wr_data0, wr_data1, wr_data2,
    output force_en, force_way, init, init_set, age_set, age_upd
  );

  modport way (
    input look_tag, look_asid, look_lru_en,
    input wr_en, wr_update, wr_invl, wr_tag, wr_asid, wr_data0, wr_data1, wr_data2,
    input force_en, force_way, init, init_set, age_set, age_upd
  );

endinterface

`default_nettype wire

// File: dtlb_ctrl.sv
// ========================================
// TLB controller: reset sweep FSM and
// driver of the broadcast bus
// ========================================
`timescale 1ns/1ps
`default_nettype none

module dtlb_ctrl (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           read_en,
  input  wire                           lru_en,
  input  wire [dtlb_pkg::tag_bits:0]    addr,  // Tag above the page-select bit
  input  wire [dtlb_pkg::asid_bits-1:0] asid,
  input  wire                           write_en,
  input  wire                           write_update,
  input  wire                           write_invl,
  input  wire [dtlb_pkg::tag_bits-1:0]  write_addr,
  input  wire [dtlb_pkg::asid_bits-1:0] write_asid,
  input  wire [dtlb_pkg::pte_bits-1:0]  write_data0,
  input  wire [dtlb_pkg::pte_bits-1:0]  write_data1,
  input  wire [dtlb_pkg::pte_bits-1:0]  write_data2,
  input  wire                           force_way_en,
  input  wire [dtlb_pkg::way_bits-1:0]  force_way,
  dtlb_bus_if.ctrl                      bus,
  output logic                          init_busy
);

  dtlb_pkg::ctrl_state_t         state;
  logic [dtlb_pkg::set_bits-1:0] init_cnt;
  logic                          running;
  logic                          wr_go;
  logic                          lru_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= dtlb_pkg::st_init;
      init_cnt <= '0;
    end else if (state == dtlb_pkg::st_init) begin
      init_cnt <= init_cnt + 1'b1;
      if (&init_cnt) state <= dtlb_pkg::st_run;  // Last set swept
    end
  end

  assign running   = (state == dtlb_pkg::st_run);
  assign init_busy = ~running;
  assign wr_go     = write_en & running;
  assign lru_go    = read_en & lru_en & running;

  assign bus.look_tag    = addr[dtlb_pkg::tag_bits:1];
  assign bus.look_asid   = asid;
  assign bus.look_lru_en = lru_go;
  assign bus.wr_en       = wr_go;
  assign bus.wr_update   = write_update;
  assign bus.wr_invl     = write_invl;
  assign bus.wr_tag      = write_addr;
  assign bus.wr_asid     = write_asid;
  assign bus.wr_data0    = write_data0;
  assign bus.wr_data1    = write_data1;
  assign bus.wr_data2    = write_data2;
  assign bus.force_en    = force_way_en;
  assign bus.force_way   = force_way;
  assign bus.init        = ~running;
  assign bus.init_set    = init_cnt;

  // A write owns the age port, else the lookup set does
  assign bus.age_set = wr_go ? write_addr[dtlb_pkg::set_bits-1:0]
                             : addr[dtlb_pkg::set_bits:1];
  assign bus.age_upd = wr_go | lru_go;

  a_cnt_frozen_in_run : assert property (@(posedge clk) disable iff (rst)
    running |=> $stable(init_cnt))
    else $error("dtlb_ctrl: sweep counter moved outside the sweep");

endmodule

`default_nettype wire

// File: dtlb_merge.sv
// ========================================
// Merge of per-way results into hit, way
// number, data pair and reference age
// ========================================
`timescale 1ns/1ps
`default_nettype none

module dtlb_merge (
  input  wire dtlb_pkg::way_result_t [dtlb_pkg::way_count-1:0] results,
  input  wire                                                  init,
  input  wire                                                  read_sel,  // Page select
  input  wire                                                  write_active,
  output logic                                                 read_hit,
  output logic [dtlb_pkg::way_bits-1:0]                        read_way,
  output logic [dtlb_pkg::pte_bits-1:0]                        read_data,
  output logic [dtlb_pkg::pte_bits-1:0]                        read_data_next,
  output logic [dtlb_pkg::age_bits-1:0]                        ref_age
);

  logic [dtlb_pkg::way_count-1:0] hit_vec;
  logic [dtlb_pkg::way_bits-1:0]  way_or;
  logic [dtlb_pkg::pte_bits-1:0]  word0;
  logic [dtlb_pkg::pte_bits-1:0]  word1;
  logic [dtlb_pkg::pte_bits-1:0]  word2;
  logic [dtlb_pkg::age_bits-1:0]  hit_age;

  // Only the hitting way contributes, so the OR is a mux
  always_comb begin
    hit_vec = '0;
    way_or  = '0;
    word0   = '0;
    word1   = '0;
    word2   = '0;
    hit_age = '0;
    for (int i = 0; i < dtlb_pkg::way_count; i++) begin
      hit_vec[i] = results[i].hit & ~init;
      if (hit_vec[i]) begin
        way_or  |= i[dtlb_pkg::way_bits-1:0];
        word0   |= results[i].pte0;
        word1   |= results[i].pte1;
        word2   |= results[i].pte2;
        hit_age |= results[i].age;
      end
    end
  end

  assign read_hit = |hit_vec;
  assign read_way = way_or;

  // Odd page starts one word further in the pair
  assign read_data      = read_sel ? word1 : word0;
  assign read_data_next = read_sel ? word2 : word1;

  // Replacement write uses the oldest way, a miss leaves ages alone
  assign ref_age = write_active ? dtlb_pkg::age_max : hit_age;

  always_comb begin
    a_single_hit : assert final ((init !== 1'b0) || $onehot0(hit_vec))
      else $error("dtlb_merge: more than one way hit, ways %b", hit_vec);
  end

endmodule

`default_nettype wire

// File: dtlb_pkg.sv
// ========================================
// Data TLB sizes, entry and way result
// structs, controller states
// ========================================
`default_nettype none

package dtlb_pkg;

  localparam int way_count = 8;
  localparam int way_bits = $clog2(way_count);
  localparam int set_count = 16;
  localparam int set_bits = 4;  // Low bits of the tag
  localparam int tag_bits = 20; // Virtual page-pair tag
  localparam int asid_bits = 8;
  localparam int pte_bits = 16;
  localparam int age_bits = 3;
  localparam logic [age_bits-1:0] age_max = '1; // Oldest way, next victim

  // Global flag inside each page-table word
  localparam int pte_glob_bit = 1;

  typedef struct packed {
    logic                 valid;
    logic                 glob;
    logic [tag_bits-1:0]  tag;
    logic [asid_bits-1:0] asid;
    logic [pte_bits-1:0]  pte0;
    logic [pte_bits-1:0]  pte1;
    logic [pte_bits-1:0]  pte2;
  } dtlb_entry_t;

  // What one way reports for the current lookup
  typedef struct packed {
    logic                hit;
    logic [pte_bits-1:0] pte0;
    logic [pte_bits-1:0] pte1;
    logic [pte_bits-1:0] pte2;
    logic [age_bits-1:0] age;  // Age at the selected age set
  } way_result_t;

  typedef enum logic {
    st_init,  // Reset sweep of all sets
    st_run
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: dtlb_tb.sv
// ========================================
// Table-driven testbench for the data TLB
// ========================================
`timescale 1ns/1ps
`default_nettype none

module dtlb_tb;

  typedef enum logic [1:0] {op_look, op_new, op_upd, op_invl} op_t;

  typedef struct packed {
    op_t                                op;
    logic [dtlb_pkg::tag_bits-1:0]      tag;
    logic                               psel;  // Page select of the lookup
    logic [dtlb_pkg::asid_bits-1:0]     asid;
    logic                               glob;  // Glob flag in all three words
    logic                               fen;
    logic [dtlb_pkg::way_bits-1:0]      fway;
    logic                               lru;
    logic                               hit;
    logic [dtlb_pkg::way_bits-1:0]      way;
    int                                 src;   // Write row whose words a hit returns
    logic [2:0][dtlb_pkg::pte_bits-1:0] data;
    logic [dtlb_pkg::pte_bits-1:0]      exp_lo;
    logic [dtlb_pkg::pte_bits-1:0]      exp_hi;
  } row_t;

  logic clk, rst, read_en, lru_en, write_en, write_update, write_invl, force_way_en;
  logic [dtlb_pkg::tag_bits:0]    addr;
  logic [dtlb_pkg::asid_bits-1:0] asid, write_asid;
  logic [dtlb_pkg::tag_bits-1:0]  write_addr;
  logic [dtlb_pkg::pte_bits-1:0]  write_data0, write_data1, write_data2;
  logic [dtlb_pkg::way_bits-1:0]  force_way, read_way;
  logic                           read_hit, init_busy;
  logic [dtlb_pkg::pte_bits-1:0]  read_data, read_data_next;
  dtlb_pkg::ctrl_state_t          st;
  row_t                           rows [$];
  integer                         seed = 32'h2df7;
  int                             errors = 0;

  dtlb dtlb_inst (.*);

  assign st = dtlb_inst.ctrl_inst.state;

  task automatic add_row(input op_t op, input int tag, input int psel, input int asid_v,
                         input int glob, input int fen, input int fway, input int lru,
                         input int hit, input int way, input int src);
    row_t r;
    r      = '0;  // Misses expect zero outputs
    r.op   = op;
    r.tag  = tag[dtlb_pkg::tag_bits-1:0];
    r.psel = psel[0];
    r.asid = asid_v[dtlb_pkg::asid_bits-1:0];
    r.glob = glob[0];
    r.fen  = fen[0];
    r.fway = fway[dtlb_pkg::way_bits-1:0];
    r.lru  = lru[0];
    r.hit  = hit[0];
    r.way  = way[dtlb_pkg::way_bits-1:0];
    r.src  = src;
    rows.push_back(r);
  endtask

  // Ways follow the age rule, the sweep leaves way k at age k
  task automatic build_table();
    // op, tag, psel, asid, glob, fen, fway, lru, hit, way, src
    add_row(op_look, 'h00013, 0, 1, 0, 0, 0, 0, 0, 0, 0);   // Empty after the sweep
    add_row(op_new,  'h00013, 0, 1, 0, 0, 0, 0, 0, 0, 0);   // Age 7 way is way 7
    add_row(op_look, 'h00013, 0, 1, 0, 0, 0, 0, 1, 7, 1);
    add_row(op_look, 'h00013, 1, 1, 0, 0, 0, 0, 1, 7, 1);
    add_row(op_look, 'h00013, 0, 2, 0, 0, 0, 0, 0, 0, 0);   // Other asid
    add_row(op_new,  'h00023, 0, 1, 1, 0, 0, 0, 0, 0, 0);   // Global entry
    add_row(op_look, 'h00023, 0, 2, 0, 0, 0, 0, 1, 6, 5);
    add_row(op_look, 'h00023, 1, 2, 0, 0, 0, 0, 1, 6, 5);
    for (int t = 1; t <= 9; t++)
      add_row(op_new, (t << 8) | 'h05, 0, 1, 0, 0, 0, 0, 0, 0, 0);  // Rows 8 to 16
    add_row(op_look, 'h00105, 0, 1, 0, 0, 0, 0, 0, 0, 0);   // Evicted by the ninth
    add_row(op_look, 'h00205, 0, 1, 0, 0, 0, 1, 1, 6, 9);   // Refresh, way 5 is oldest
    add_row(op_new,  'h00a05, 0, 1, 0, 0, 0, 0, 0, 0, 0);
    add_row(op_look, 'h00305, 0, 1, 0, 0, 0, 0, 0, 0, 0);
    add_row(op_look, 'h00205, 0, 1, 0, 0, 0, 0, 1, 6, 9);
    add_row(op_look, 'h00a05, 1, 1, 0, 0, 0, 0, 1, 5, 19);
    add_row(op_new,  'h00019, 0, 3, 0, 0, 0, 0, 0, 0, 0);
    add_row(op_upd,  'h00019, 0, 3, 0, 0, 0, 0, 0, 0, 0);
    add_row(op_look, 'h00019, 1, 3, 0, 0, 0, 0, 1, 7, 24);
    add_row(op_new,  'h00029, 0, 3, 0, 1, 2, 0, 0, 0, 0);   // Forced into way 2
    add_row(op_look, 'h00029, 0, 3, 0, 0, 0, 0, 1, 2, 26);
    add_row(op_invl, 'h00019, 0, 3, 0, 0, 0, 0, 0, 0, 0);
    add_row(op_look, 'h00019, 0, 3, 0, 0, 0, 0, 0, 0, 0);
    add_row(op_look, 'h00029, 1, 3, 0, 0, 0, 0, 1, 2, 26);
  endtask

  // Random words, then the expected pair of each hitting lookup
  task automatic fill_data();
    row_t r;
    int   rnd;
    foreach (rows[i]) begin
      r = rows[i];
      for (int w = 0; w < 3; w++) begin
        rnd = $random(seed);
        r.data[w] = rnd[dtlb_pkg::pte_bits-1:0];
        r.data[w][dtlb_pkg::pte_glob_bit] = r.glob;
      end
      if (r.op == op_look && r.hit) begin
        r.exp_lo = rows[r.src].data[int'(r.psel)];
        r.exp_hi = rows[r.src].data[int'(r.psel) + 1];  // Next page follows
      end
      rows[i] = r;
    end
  endtask

  task automatic drive_row(input row_t r);
    read_en      <= (r.op == op_look);
    lru_en       <= r.lru;
    addr         <= {r.tag, r.psel};
    asid         <= r.asid;
    write_en     <= (r.op != op_look);
    write_update <= (r.op == op_upd) || (r.op == op_invl);
    write_invl   <= (r.op == op_invl);
    write_addr   <= r.tag;
    write_asid   <= r.asid;
    write_data0  <= r.data[0];
    write_data1  <= r.data[1];
    write_data2  <= r.data[2];
    force_way_en <= r.fen;
    force_way    <= r.fway;
  endtask

  task automatic check_row(input int n, input row_t r);
    if (read_hit !== r.hit || read_way !== r.way || read_data !== r.exp_lo ||
        read_data_next !== r.exp_hi) begin
      $display("MISMATCH at %0t: row %0d got hit %b way %0d data %h %h, expected %b %0d %h %h",
               $time, n, read_hit, read_way, read_data, read_data_next,
               r.hit, r.way, r.exp_lo, r.exp_hi);
      errors++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Two cycles per row plus the reset sweep and some slack
  initial begin
    @(negedge rst);
    #((rows.size() * 2 + 40) * 20);
    $display("Timeout: the run did not finish within the expected time");
    $display("sim failed");
    $finish;
  end

  initial begin
    int cycles;
    cycles = 0;
    build_table();
    fill_data();
    rst = 1'b1;
    {read_en, lru_en, write_en, write_update, write_invl, force_way_en} = '0;
    {addr, asid, write_addr, write_asid, force_way} = '0;
    {write_data0, write_data1, write_data2} = '0;
    repeat (3) @(posedge clk);
    rst        <= 1'b0;
    read_en    <= 1'b1;  // Same tag looked up and written while the sweep runs
    addr       <= {20'h00013, 1'b0};
    asid       <= 8'd1;
    write_en   <= 1'b1;
    write_addr <= 20'h00013;
    write_asid <= 8'd1;
    @(negedge clk);
    while (init_busy === 1'b1) begin
      cycles++;
      if (read_hit !== 1'b0 || read_way !== '0 || read_data !== '0 || read_data_next !== '0) begin
        $display("MISMATCH at %0t: lookup output active in state %s", $time, st.name());
        errors++;
      end
      @(posedge clk);
      if (cycles == 8)
        write_en <= 1'b0;  // Set 3 is swept by now, so the write must be dropped
      @(negedge clk);
    end
    if (cycles != 16) begin
      $display("MISMATCH at %0t: init_busy high for %0d cycles, expected 16", $time, cycles);
      errors++;
    end
    foreach (rows[i]) begin
      @(posedge clk);
      drive_row(rows[i]);
      @(negedge clk);  // Lookup outputs settled mid-cycle
      if (rows[i].op == op_look)
        check_row(i, rows[i]);
    end
    @(posedge clk);
    read_en  <= 1'b0;
    write_en <= 1'b0;
    $display("Done: %0d rows, %0d errors", rows.size(), errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dtlb_way.sv
// ========================================
// One TLB way: entries, ages, hit compare
// and write and age update
// ========================================
`timescale 1ns/1ps
`default_nettype none

module dtlb_way #(
  parameter int way_no = 0
) (
  input  wire                          clk,
  input  wire                          rst,
  dtlb_bus_if.way                      bus,
  input  wire [dtlb_pkg::age_bits-1:0] ref_age,  // Age of the way being used
  output dtlb_pkg::way_result_t        result
);

  localparam logic [dtlb_pkg::way_bits-1:0] way_id   = way_no[dtlb_pkg::way_bits-1:0];
  localparam logic [dtlb_pkg::age_bits-1:0] init_age = way_no[dtlb_pkg::age_bits-1:0];

  dtlb_pkg::dtlb_entry_t         entries [dtlb_pkg::set_count];
  logic [dtlb_pkg::age_bits-1:0] ages [dtlb_pkg::set_count];

  dtlb_pkg::dtlb_entry_t         look_entry;
  dtlb_pkg::dtlb_entry_t         wr_entry;
  dtlb_pkg::dtlb_entry_t         new_entry;
  logic [dtlb_pkg::set_bits-1:0] look_set;
  logic [dtlb_pkg::set_bits-1:0] wr_set;
  logic [dtlb_pkg::set_bits-1:0] entry_set;
  logic [dtlb_pkg::age_bits-1:0] cur_age;
  logic [dtlb_pkg::age_bits-1:0] next_age;
  logic                          look_hit;
  logic                          wr_hit;
  logic                          force_me;
  logic                          entry_we;

  // Tag must match, and either the asid or the global bit
  function automatic logic entry_match(
    input dtlb_pkg::dtlb_entry_t         e,
    input logic [dtlb_pkg::tag_bits-1:0]  tag,
    input logic [dtlb_pkg::asid_bits-1:0] asid
  );
    return e.valid && (e.tag == tag) && ((e.asid == asid) || e.glob);
  endfunction

  assign look_set   = bus.look_tag[dtlb_pkg::set_bits-1:0];
  assign wr_set     = bus.wr_tag[dtlb_pkg::set_bits-1:0];
  assign look_entry = entries[look_set];
  assign wr_entry   = entries[wr_set];
  assign cur_age    = ages[bus.age_set];

  assign look_hit = ~bus.init & entry_match(look_entry, bus.look_tag, bus.look_asid);
  assign wr_hit   = entry_match(wr_entry, bus.wr_tag, bus.wr_asid);

  assign result = '{hit: look_hit, pte0: look_entry.pte0, pte1: look_entry.pte1,
                    pte2: look_entry.pte2, age: cur_age};

  // A forced write goes only to the named way
  assign force_me = bus.force_en && (bus.force_way == way_id);
  assign entry_we = bus.init | (bus.wr_en & (bus.force_en ? force_me :
                    (bus.wr_update ? wr_hit : (cur_age == dtlb_pkg::age_max))));
  assign entry_set = bus.init ? bus.init_set : wr_set;

  always_comb begin
    new_entry = '0;  // Sweep writes an empty entry
    if (!bus.init) begin
      new_entry.valid = ~bus.wr_invl;
      new_entry.glob  = bus.wr_data0[dtlb_pkg::pte_glob_bit] &
                        bus.wr_data1[dtlb_pkg::pte_glob_bit] &
                        bus.wr_data2[dtlb_pkg::pte_glob_bit];
      new_entry.tag   = bus.wr_tag;
      new_entry.asid  = bus.wr_asid;
      new_entry.pte0  = bus.wr_data0;
      new_entry.pte1  = bus.wr_data1;
      new_entry.pte2  = bus.wr_data2;
    end
  end

  // The used way becomes youngest, younger ones age by one
  always_comb begin
    if (cur_age == ref_age) next_age = '0;
    else if (cur_age < ref_age) next_age = cur_age + 1'b1;
    else next_age = cur_age;
  end

  always_ff @(posedge clk) begin
    if (entry_we) entries[entry_set] <= new_entry;
    if (bus.init) ages[bus.init_set] <= init_age;  // Way k starts at age k
    else if (bus.age_upd) ages[bus.age_set] <= next_age;
  end

  // Each set swept is left without a valid entry
  a_sweep_clears : assert property (@(posedge clk) disable iff (rst)
    bus.init |=> !entries[$past(bus.init_set)].valid)
    else $error("dtlb_way %0d: entry still valid after its sweep cycle", way_no);

endmodule

`default_nettype wire

// File: sim.f
dtlb_pkg.sv
dtlb_bus_if.sv
dtlb_ctrl.sv
dtlb_way.sv
dtlb_merge.sv
dtlb.sv
dtlb_tb.sv
